// ==== Bender.yml ====
package:
  name: decode_stage

dependencies: {}

sources:
  - files:
      - verilog/decode_pkg.sv
      - verilog/instruction_decoder.sv
      - verilog/imm_gen.sv
      - verilog/reg_file.sv
      - verilog/id_ex_reg.sv
      - verilog/decode_stage.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/decode_stage_tb.sv

// ==== project.f ====
verilog/decode_pkg.sv
verilog/instruction_decoder.sv
verilog/imm_gen.sv
verilog/reg_file.sv
verilog/id_ex_reg.sv
verilog/decode_stage.sv
sim/clk_gen.sv
sim/decode_stage_tb.sv

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period, first rising edge at 10 ns
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // low over the first 16 rising edges, released just after the 16th
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

// ==== sim/decode_patterns.txt ====
# columns: instruction word, pc, expected ctrl word (28 bits), expected immediate, all hex
# ctrl msb first: write_en rd_en wrt_en unsigned_sel width jalr rti data_sel auipc alu_op ...
00510093 00001000 80C0300 00000005  # addi x1, x2, 5
FFF20193 00001004 80E0300 FFFFFFFF  # addi x3, x4, -1
7FF34293 00001008 80F0300 000007FF  # xori x5, x6, 0x7ff
40345393 0000100C 80F4300 00000403  # srai x7, x8, 3
00B504B3 00001010 8040300 0000000B  # add x9, x10, x11
40E68633 00001014 8060300 0000040E  # sub x12, x13, x14
011837B3 00001018 804C300 00000011  # sltu x15, x16, x17
12345097 0000101C 8094360 12345000  # auipc x1, 0x12345
FFFFF137 00001020 80FC360 FFFFF000  # lui x2, 0xfffff
00822183 00001024 C0C8200 00000008  # lw x3, 8(x4)
FFC34283 00001028 D4F0200 FFFFFFFC  # lbu x5, -4(x6)
00245383 0000102C D8D4200 00000002  # lhu x7, 2(x8)
00651483 00001030 C8C4200 00000006  # lh x9, 6(x10)
00B62623 00001034 20C8320 0000000C  # sw x11, 12(x12)
FED70C23 00001038 24E0320 FFFFFFF8  # sb x13, -8(x14)
06F81F23 0000103C 28C4320 0000007E  # sh x15, 126(x16)
0010006F 00001040 80C2D80 00000800  # jal x1, +2048
FFDFF06F 00001044 80FED80 FFFFFFFC  # jal x0, -4
010280E7 00001048 02C2D00 00000010  # jalr x1, 16(x5)
00208863 0000104C 00C2340 00000010  # beq x1, x2, +16
FE419CE3 00001050 00E6740 FFFFFFF8  # bne x3, x4, -8
7E62FF63 00001054 00FFF40 000007FE  # bgeu x5, x6, +2046
00000008 00001058 01C0300 00000000  # rti
10038009 0000105C 00C0301 00000100  # set_ireg x7, 0x100
0000020A 00001060 80C0200 00000000  # net_recv x4
0051800B 00001064 00C0302 00000005  # net_send x3, x5
00008028 00001068 00C0308 00000000  # ppu_send x1
00000329 0000106C 80C0004 00000000  # acc_send x6
000003AA 00001070 80C0211 00000000  # random x7
0000007F 00001074 00C0300 00000000  # unknown opcode, decodes as nop

// ==== sim/decode_stage_tb.sv ====
`timescale 1ns/1ns

module decode_stage_tb;
    import decode_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    instr_u      instruction;
    logic [31:0] pc;
    logic        stall;
    logic        flush;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    id_ex_t      ex;

    // pattern columns are word, pc, expected ctrl and expected immediate
    logic [31:0] pat_word [$];
    logic [31:0] pat_pc   [$];
    logic [31:0] pat_ctrl [$];
    logic [31:0] pat_imm  [$];

    // what the register file should hold
    logic [31:0] model_regs [0:31];

    int checks;
    int errors;
    int cycles;
    int limit;

    clk_gen clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    decode_stage dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instruction (instruction),
        .pc          (pc),
        .stall       (stall),
        .flush       (flush),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .ex          (ex)
    );

    // watchdog stays idle while limit is 0
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Something failed");
            $finish;
        end
    end

    task automatic read_patterns;
        int          fd;
        string       line;
        logic [31:0] w;
        logic [31:0] p;
        logic [31:0] c;
        logic [31:0] i;
        fd = $fopen("sim/decode_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file sim/decode_patterns.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd)) begin
            // skip comments and blank lines
            if (line.len() < 8 || line.getc(0) == "#") begin
                continue;
            end
            if ($sscanf(line, "%h %h %h %h", w, p, c, i) == 4) begin
                pat_word.push_back(w);
                pat_pc.push_back(p);
                pat_ctrl.push_back(c);
                pat_imm.push_back(i);
            end
        end
        $fclose(fd);
    endtask

    // advance to 2 ns after the next rising edge, where inputs change
    task automatic tick;
        @(posedge clk);
        #2;
    endtask

    task automatic present(input logic [31:0] word, input logic [31:0] addr,
                           input logic valid);
        instruction = word;
        pc          = addr;
        instr_valid = valid;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // bubble means valid low and no control strobes
    task automatic check_bubble(input string when);
        check_value({"ex.valid ", when}, ex.valid, 32'd0);
        check_value({"ex.ctrl ", when}, ex.ctrl, 32'd0);
    endtask

    // register fields sit at fixed ISA positions in every format
    task automatic check_decode(input int idx);
        logic [31:0] w;
        w = pat_word[idx];
        check_value("ex.valid", ex.valid, 32'd1);
        check_value("ex.ctrl", ex.ctrl, pat_ctrl[idx]);
        check_value("ex.imm", ex.imm, pat_imm[idx]);
        check_value("ex.pc", ex.pc, pat_pc[idx]);
        check_value("ex.rd", ex.rd, w[11:7]);
        check_value("ex.rs1", ex.rs1, w[19:15]);
        check_value("ex.rs2", ex.rs2, w[24:20]);
        check_value("ex.rs1_data", ex.rs1_data, model_regs[w[19:15]]);
        check_value("ex.rs2_data", ex.rs2_data, model_regs[w[24:20]]);
    endtask

    // R-type add, used to read two chosen registers
    function automatic logic [31:0] make_add(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    initial begin
        id_ex_t      held;
        logic [31:0] new_val;
        void'($urandom(46));
        checks = 0;
        errors = 0;
        cycles = 0;
        limit  = 0;
        // addi x1, x2, 5 held valid through reset
        present(32'h00510093, 32'h0, 1'b1);
        stall   = 1'b0;
        flush   = 1'b0;
        wb_en   = 1'b0;
        wb_addr = 5'd0;
        wb_data = 32'h0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'h0;
        end
        read_patterns();
        limit = 4 * pat_word.size() + 200;

        // reset holds a bubble up to the first cycle after release
        do begin
            @(negedge clk);
            check_bubble("in reset");
        end while (rst_n !== 1'b1);
        tick();

        if (pat_word.size() < 8) begin
            $display("too few patterns read, %0d found", pat_word.size());
            errors++;
        end else begin
            // decode every pattern against a cleared register file
            foreach (pat_word[i]) begin
                present(pat_word[i], pat_pc[i], 1'b1);
                tick();
                check_decode(i);
            end

            // fill all registers, x0 included, with random values
            present(32'h00000013, 32'h0, 1'b0);
            for (int r = 0; r < 32; r++) begin
                wb_en   = 1'b1;
                wb_addr = r[4:0];
                wb_data = $urandom;
                if (r != 0) begin
                    model_regs[r] = wb_data;
                end
                tick();
            end
            wb_en = 1'b0;
            // read back in pairs, x0 on both ports once
            for (int r = 0; r < 32; r++) begin
                present(make_add(5'd1, r[4:0], 5'd31 - r[4:0]), 32'h2000 + 4 * r, 1'b1);
                tick();
                check_value("ex.rs1_data", ex.rs1_data, model_regs[r]);
                check_value("ex.rs2_data", ex.rs2_data, model_regs[31 - r]);
            end

            // same-cycle write of x5 seen on both read ports
            new_val = $urandom;
            present(make_add(5'd3, 5'd5, 5'd5), 32'h3000, 1'b1);
            wb_en   = 1'b1;
            wb_addr = 5'd5;
            wb_data = new_val;
            tick();
            check_value("bypass rs1_data", ex.rs1_data, new_val);
            check_value("bypass rs2_data", ex.rs2_data, new_val);
            model_regs[5] = new_val;
            wb_en = 1'b0;
            tick();
            check_value("stored rs1_data", ex.rs1_data, model_regs[5]);
            // x0 never bypasses
            present(make_add(5'd1, 5'd0, 5'd0), 32'h3004, 1'b1);
            wb_en   = 1'b1;
            wb_addr = 5'd0;
            wb_data = $urandom;
            tick();
            check_value("x0 rs1_data", ex.rs1_data, 32'h0);
            check_value("x0 rs2_data", ex.rs2_data, 32'h0);
            wb_en = 1'b0;

            // stall holds the captured bundle while inputs move on
            present(pat_word[0], pat_pc[0], 1'b1);
            tick();
            held  = ex;
            stall = 1'b1;
            for (int k = 1; k < 4; k++) begin
                present(pat_word[k], pat_pc[k], 1'b1);
                tick();
                checks++;
                if (ex !== held) begin
                    errors++;
                    $display("** Error at %0t ns: ex changed during stall", $time);
                end
            end
            stall = 1'b0;
            tick();
            check_decode(3);

            // flush alone clears the valid bundle left by the stall test
            present(pat_word[5], pat_pc[5], 1'b1);
            flush = 1'b1;
            tick();
            check_bubble("after flush");
            // reload a valid bundle so the next flush has something to clear
            flush = 1'b0;
            present(pat_word[6], pat_pc[6], 1'b1);
            tick();
            check_decode(6);
            // flush over stall
            flush = 1'b1;
            stall = 1'b1;
            tick();
            check_bubble("after flush with stall");
            flush = 1'b0;
            stall = 1'b0;
            present(pat_word[7], pat_pc[7], 1'b1);
            tick();
            check_decode(7);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog/decode_pkg.sv ====
package decode_pkg;

    // base ISA major opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // custom opcodes for interrupts, network, ppu, accelerator and rng
    localparam logic [6:0] op_rti      = 7'b0001000;
    localparam logic [6:0] op_set_ireg = 7'b0001001;
    localparam logic [6:0] op_net_recv = 7'b0001010;
    localparam logic [6:0] op_net_send = 7'b0001011;
    localparam logic [6:0] op_ppu_send = 7'b0101000;
    localparam logic [6:0] op_acc_send = 7'b0101001;
    localparam logic [6:0] op_random   = 7'b0101010;

    // which immediate layout the instruction carries
    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_kind_e;

    // write-back source mux select
    typedef enum logic [1:0] {
        wb_acc  = 2'd0,
        wb_link = 2'd1,
        wb_ext  = 2'd2,
        wb_alu  = 2'd3
    } wb_sel_e;

    // memory access size
    typedef enum logic [1:0] {
        width_word = 2'd0,
        width_byte = 2'd1,
        width_half = 2'd2
    } mem_width_e;

    // decoded control fields, all strobes active high except data_sel/auipc
    typedef struct packed {
        logic       write_en;
        logic       rd_en;
        logic       wrt_en;
        logic       unsigned_sel;
        mem_width_e width;
        logic       jalr;
        logic       rti;
        logic       data_sel;
        logic       auipc;
        logic [3:0] alu_op;
        logic [3:0] bj_inst;
        wb_sel_e    wb_sel;
        imm_kind_e  imm_kind;
        logic       random;
        logic       ppu_send;
        logic       sac;
        logic       snd;
        logic       rsi;
    } ctrl_t;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one 32-bit word, read through whichever format applies
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // everything execute needs from decode
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        ctrl_t       ctrl;
    } id_ex_t;

endpackage

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  decode_pkg::instr_u instruction,
    input  logic [31:0]        pc,
    input  logic               stall,
    input  logic               flush,
    input  logic               wb_en,
    input  logic [4:0]         wb_addr,
    input  logic [31:0]        wb_data,
    output decode_pkg::id_ex_t ex
);
    import decode_pkg::*;

    ctrl_t       ctrl;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    id_ex_t      bundle;

    instruction_decoder u_decoder (
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    imm_gen u_imm_gen (
        .instruction (instruction),
        .imm_kind    (ctrl.imm_kind),
        .imm         (imm)
    );

    // register numbers taken from the r view, same bits in all formats
    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (instruction.r.rs1),
        .rs2      (instruction.r.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    // gather the bundle, valid is attached inside id_ex_reg
    always_comb begin
        bundle.valid    = 1'b0;
        bundle.pc       = pc;
        bundle.rs1_data = rs1_data;
        bundle.rs2_data = rs2_data;
        bundle.imm      = imm;
        bundle.rd       = instruction.r.rd;
        bundle.rs1      = instruction.r.rs1;
        bundle.rs2      = instruction.r.rs2;
        bundle.ctrl     = ctrl;
    end

    id_ex_reg u_id_ex_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .flush       (flush),
        .instr_valid (instr_valid),
        .d           (bundle),
        .q           (ex)
    );

endmodule

// ==== verilog/id_ex_reg.sv ====
`timescale 1ns/1ns

module id_ex_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic               instr_valid,
    input  decode_pkg::id_ex_t d,
    output decode_pkg::id_ex_t q
);
    import decode_pkg::*;

    id_ex_t nxt;

    // incoming bundle tagged with the fetch valid
    always_comb begin
        nxt       = d;
        nxt.valid = instr_valid;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            // bubble, payload left as is since valid is low
            q.valid <= 1'b0;
            q.ctrl  <= '0;
        end else if (!stall) begin
            q <= nxt;
        end
        // stall without flush holds q
    end

    // a flushed slot never reaches execute as valid
    flush_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !q.valid
    ) else $error("ex.valid high one cycle after flush");

endmodule

// ==== verilog/imm_gen.sv ====
`timescale 1ns/1ns

module imm_gen (
    input  decode_pkg::instr_u    instruction,
    input  decode_pkg::imm_kind_e imm_kind,
    output logic [31:0]           imm
);
    import decode_pkg::*;

    logic sign;

    // every format keeps the immediate sign in bit 31
    assign sign = instruction.r.funct7[6];

    always_comb begin
        case (imm_kind)
            imm_i: begin
                imm = {{20{sign}}, instruction.i.imm_11_0};
            end
            imm_s: begin
                // split around rd position
                imm = {{20{sign}},
                       instruction.s.imm_11_5,
                       instruction.s.imm_4_0};
            end
            imm_b: begin
                // halfword offset, bit 0 always zero
                imm = {{19{sign}},
                       instruction.b.imm_12,
                       instruction.b.imm_11,
                       instruction.b.imm_10_5,
                       instruction.b.imm_4_1,
                       1'b0};
            end
            imm_u: begin
                imm = {instruction.u.imm_31_12, 12'b0};
            end
            imm_j: begin
                // jal offset, scrambled bit order in the word
                imm = {{11{sign}},
                       instruction.j.imm_20,
                       instruction.j.imm_19_12,
                       instruction.j.imm_11,
                       instruction.j.imm_10_1,
                       1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== verilog/instruction_decoder.sv ====
`timescale 1ns/1ns

module instruction_decoder (
    input  decode_pkg::instr_u instruction,
    output decode_pkg::ctrl_t  ctrl
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       bit30;

    // opcode, funct3 and bit 30 sit at the same place in every format
    assign opcode = instruction.r.opcode;
    assign funct3 = instruction.r.funct3;
    assign bit30  = instruction.r.funct7[5];

    // load and store share the size encoding in funct3[1:0]
    function automatic mem_width_e size_of(input logic [2:0] f3);
        mem_width_e w;
        case (f3[1:0])
            2'b00:   w = width_byte;
            2'b01:   w = width_half;
            default: w = width_word;
        endcase
        return w;
    endfunction

    always_comb begin
        // idle defaults give no strobes with the alu on the immediate and pc not passed
        ctrl          = '0;
        ctrl.data_sel = 1'b1;
        ctrl.auipc    = 1'b1;
        ctrl.wb_sel   = wb_alu;
        ctrl.imm_kind = imm_i;
        ctrl.width    = width_word;
        // alu op straight from the word and ignored by execute where unused
        ctrl.alu_op   = {bit30, funct3};

        case (opcode)
            op_imm: begin
                ctrl.write_en = 1'b1;
            end
            op_reg: begin
                ctrl.write_en = 1'b1;
                // second alu operand from rs2
                ctrl.data_sel = 1'b0;
            end
            op_auipc: begin
                ctrl.write_en = 1'b1;
                // low selects pc into the alu
                ctrl.auipc    = 1'b0;
                ctrl.imm_kind = imm_u;
            end
            op_lui: begin
                ctrl.write_en = 1'b1;
                ctrl.imm_kind = imm_u;
            end
            op_load: begin
                ctrl.write_en     = 1'b1;
                ctrl.rd_en        = 1'b1;
                ctrl.wb_sel       = wb_ext;
                ctrl.width        = size_of(funct3);
                // lbu and lhu zero-extend
                ctrl.unsigned_sel = (funct3 == 3'b100) || (funct3 == 3'b101);
            end
            op_store: begin
                ctrl.wrt_en   = 1'b1;
                ctrl.width    = size_of(funct3);
                ctrl.imm_kind = imm_s;
            end
            op_jal: begin
                ctrl.write_en = 1'b1;
                ctrl.wb_sel   = wb_link;
                ctrl.bj_inst  = 4'b1011;
                ctrl.imm_kind = imm_j;
            end
            op_jalr: begin
                // link goes through wb_sel while write_en follows the core's rule
                ctrl.jalr    = 1'b1;
                ctrl.wb_sel  = wb_link;
                ctrl.bj_inst = 4'b1011;
            end
            op_branch: begin
                ctrl.bj_inst  = {1'b1, funct3};
                ctrl.imm_kind = imm_b;
            end
            op_rti: begin
                ctrl.rti = 1'b1;
            end
            op_set_ireg: begin
                ctrl.rsi = 1'b1;
            end
            op_net_recv: begin
                ctrl.write_en = 1'b1;
                ctrl.wb_sel   = wb_ext;
            end
            op_net_send: begin
                ctrl.snd = 1'b1;
            end
            op_ppu_send: begin
                ctrl.ppu_send = 1'b1;
            end
            op_acc_send: begin
                // result comes back from the accelerator
                ctrl.write_en = 1'b1;
                ctrl.sac      = 1'b1;
                ctrl.wb_sel   = wb_acc;
            end
            op_random: begin
                ctrl.write_en = 1'b1;
                ctrl.random   = 1'b1;
                ctrl.rsi      = 1'b1;
                ctrl.wb_sel   = wb_ext;
            end
            default: begin
                // unknown opcode decodes as a nop
            end
        endcase
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        wb_en,
    input  logic [4:0]  wb_addr,
    input  logic [31:0] wb_data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    // one read port: zero for x0, then writeback bypass, then storage
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        logic [31:0] val;
        if (addr == 5'd0) begin
            val = '0;
        end else if (wb_en && (wb_addr == addr)) begin
            // same-cycle write wins
            val = wb_data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_addr != 5'd0)) begin
            // writes to x0 dropped
            regs[wb_addr] <= wb_data;
        end
    end

    // writeback must present a clean address whenever it writes
    wb_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_en |-> !$isunknown(wb_addr)
    ) else $error("wb_addr has unknown bits during a write");

endmodule
